/* project.f */
verilog/ExecTypes.sv
verilog/IntAlu.sv
verilog/MulDivUnit.sv
verilog/LoadStoreUnit.sv
verilog/DataRam.sv
verilog/ExecuteStage.sv
verilog/ExecuteSubsystem.sv
testbench/ExecuteSubsystemTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = ExecuteSubsystemTb
FILELIST  = project.f
PASS_TEXT = all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

/* testbench/executeInput.txt */
# opcode src1Sel src2Sel branchType pc imm src1 src2 expectedResult expectedTaken, all hex
# opcode 0-9 integer ops, a mul, b mulhu, c divu, d remu, e load, f store, 10 branch, 11 jal
0 2 2 0 00000100 00000000 00000005 00000007 0000000c 0
0 1 1 0 00001000 00000010 00000000 00000000 00001010 0
0 0 1 0 00000104 fffff800 12345678 00000000 fffff800 0
1 2 2 0 00000108 00000000 00000003 00000005 fffffffe 0
2 2 2 0 0000010c 00000000 00000001 0000001f 80000000 0
2 2 2 0 00000110 00000000 00000003 00000021 00000006 0
3 2 2 0 00000114 00000000 ffffffff 00000001 00000001 0
4 2 2 0 00000118 00000000 ffffffff 00000001 00000000 0
4 2 1 0 0000011c 00000010 00000001 00000000 00000001 0
5 2 2 0 00000120 00000000 f0f0f0f0 ff00ff00 0ff00ff0 0
6 2 2 0 00000124 00000000 80000000 0000001f 00000001 0
6 2 2 0 00000128 00000000 80000000 00000020 80000000 0
7 2 2 0 0000012c 00000000 80000000 00000004 f8000000 0
7 2 2 0 00000130 00000000 80000000 0000003f ffffffff 0
8 2 1 0 00000134 00000f00 000000ff 00000000 00000fff 0
9 2 2 0 00000138 00000000 12345678 0000ffff 00005678 0
10 1 1 0 00000200 00000040 00000005 00000005 00000240 1
10 1 1 1 00000204 00000040 00000005 00000005 00000244 0
10 1 1 2 00000208 fffffff0 ffffffff 00000001 000001f8 1
10 1 1 3 0000020c 00000010 ffffffff 00000001 0000021c 0
10 1 1 4 00000210 00000020 ffffffff 00000001 00000230 0
10 1 1 5 00000214 00000020 ffffffff 00000001 00000234 1
11 1 1 0 00000300 00000100 00000000 00000000 00000304 0
a 2 2 0 00000400 00000000 00010003 00020005 000b000f 0
b 2 2 0 00000404 00000000 ffffffff ffffffff fffffffe 0
c 2 2 0 00000408 00000000 00000064 00000007 0000000e 0
d 2 2 0 0000040c 00000000 00000064 00000007 00000002 0
f 2 1 0 00000410 00000010 00000100 cafef00d 00000110 0
c 2 2 0 00000414 00000000 12345678 00000000 ffffffff 0
e 2 1 0 00000418 00000000 00000110 00000000 cafef00d 0
d 2 2 0 0000041c 00000000 12345678 00000000 12345678 0
e 2 1 0 00000420 00000004 00000110 00000000 00000000 0
f 2 1 0 00000424 fffffffc 00000118 0badbeef 00000114 0
e 2 1 0 00000428 00000014 00000100 00000000 0badbeef 0
f 2 1 0 0000042c 00000000 00000110 00000001 00000110 0
e 2 1 0 00000430 00000000 00000110 00000000 00000001 0

/* testbench/ExecuteSubsystemTb.sv */
// Execute subsystem testbench
// Runs operation vectors from a data file, then LFSR-generated ALU ops,
// and checks every result record in order against the expected values.

`timescale 1ns/1ns
`default_nettype none

module ExecuteSubsystemTb;
    localparam int HalfPeriod = 4;
    localparam int RandomOps = 40;
    localparam logic [31:0] LfsrTaps = 32'h80200003;

    logic                 clk;
    logic                 reset;
    ExecTypes::ExecOp     op;
    logic                 stall;
    ExecTypes::ExecResult result;

    ExecTypes::ExecOp     fileOps[$];
    ExecTypes::ExecResult fileExp[$];
    ExecTypes::ExecResult expectQueue[$];
    string                nameQueue[$];
    logic [31:0]          lfsrState = 32'h7f58;
    int                   acceptedCount = 0;
    int                   resultCount = 0;
    int                   cycleCount = 0;
    int                   cycleLimit = 0;

    ExecuteSubsystem #(
        .DivCycles(32),
        .RamWords(256)
    ) ExecuteSubsystem_i (
        .clk(clk),
        .reset(reset),
        .op(op),
        .stall(stall),
        .result(result)
    );

    always #HalfPeriod clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("tests failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic checkValue(input string testName, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s %s expected %h actual %h", testName, field, expected, actual);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ LfsrTaps) : (lfsrState >> 1);
        end
        return value;
    endfunction

    function automatic ExecTypes::word_t aluModel(input ExecTypes::ExecOpcode opcode,
                                                 input ExecTypes::word_t a,
                                                 input ExecTypes::word_t b);
        ExecTypes::word_t value;
        case (opcode)
            ExecTypes::ExecOpcode_Add:  value = a + b;
            ExecTypes::ExecOpcode_Sub:  value = a - b;
            ExecTypes::ExecOpcode_Sll:  value = a << b[4:0];
            ExecTypes::ExecOpcode_Slt:  value = {31'b0, $signed(a) < $signed(b)};
            ExecTypes::ExecOpcode_Sltu: value = {31'b0, a < b};
            ExecTypes::ExecOpcode_Xor:  value = a ^ b;
            ExecTypes::ExecOpcode_Srl:  value = a >> b[4:0];
            ExecTypes::ExecOpcode_Sra:  value = $unsigned($signed(a) >>> b[4:0]);
            ExecTypes::ExecOpcode_Or:   value = a | b;
            ExecTypes::ExecOpcode_And:  value = a & b;
            default:                    value = '0;
        endcase
        return value;
    endfunction

    task automatic loadVectors();
        int          fd;
        int          count;
        int          index;
        string       line;
        logic [31:0] code, sel1, sel2, brType, pc, imm, a, b, expValue, expTaken;
        ExecTypes::ExecOp     o;
        ExecTypes::ExecResult e;
        index = 0;
        fd = $fopen("testbench/executeInput.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/executeInput.txt");
            $display("tests failed");
            $fatal(1, "missing input file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", code, sel1, sel2,
                                    brType, pc, imm, a, b, expValue, expTaken);
                    if (count != 10) begin
                        $display("malformed line in input file: %s", line);
                        $display("tests failed");
                        $fatal(1, "bad input file");
                    end else begin
                        o = '0;
                        o.valid = 1'b1;
                        o.opcode = ExecTypes::ExecOpcode'(code[4:0]);
                        o.aluSrc1 = ExecTypes::AluSrc1Type'(sel1[1:0]);
                        o.aluSrc2 = ExecTypes::AluSrc2Type'(sel2[1:0]);
                        o.branchType = ExecTypes::BranchType'(brType[2:0]);
                        o.pc = pc;
                        o.imm = imm;
                        o.src1Value = a;
                        o.src2Value = b;
                        o.dstReg = 5'(index);
                        e = '0;
                        e.valid = 1'b1;
                        e.pc = pc;
                        e.dstReg = 5'(index);
                        e.result = expValue;
                        e.branchTaken = expTaken[0];
                        // taken branch and jal go to pc + imm
                        if (o.opcode == ExecTypes::ExecOpcode_Jal || expTaken[0]) begin
                            e.nextPc = pc + imm;
                        end else begin
                            e.nextPc = pc + 32'd4;
                        end
                        fileOps.push_back(o);
                        fileExp.push_back(e);
                        index++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // drive on the falling edge, hold while stalled
    task automatic issueOp(input ExecTypes::ExecOp nextOp, input ExecTypes::ExecResult expected,
                           input string testName);
        logic expectStall;
        logic stalled;
        logic waiting;
        expectStall = nextOp.opcode inside {ExecTypes::ExecOpcode_Mul,
            ExecTypes::ExecOpcode_Mulhu, ExecTypes::ExecOpcode_Divu,
            ExecTypes::ExecOpcode_Remu, ExecTypes::ExecOpcode_Load,
            ExecTypes::ExecOpcode_Store};
        op = nextOp;
        expectQueue.push_back(expected);
        nameQueue.push_back(testName);
        stalled = 1'b0;
        waiting = 1'b1;
        while (waiting) begin
            #(HalfPeriod / 2);
            if (stalled) begin
                checkValue(testName, "result valid under stall", 32'd0, 32'(result.valid));
            end
            if (stall === 1'b0) begin
                waiting = 1'b0;
            end else begin
                stalled = 1'b1;
                @(negedge clk);
            end
        end
        checkValue(testName, "stall seen", 32'(expectStall), 32'(stalled));
        acceptedCount++;
        @(negedge clk);
    endtask

    task automatic runRandomOps();
        logic [4:0]           code;
        ExecTypes::word_t     operand2;
        ExecTypes::ExecOp     o;
        ExecTypes::ExecResult e;
        for (int i = 0; i < RandomOps; i++) begin
            code = 5'(randomBits(4) % 10);
            o = '0;
            o.valid = 1'b1;
            o.opcode = ExecTypes::ExecOpcode'(code);
            o.aluSrc1 = ExecTypes::AluSrc1Type_Reg;
            o.aluSrc2 = randomBits(1) == 32'd1 ? ExecTypes::AluSrc2Type_Imm
                                               : ExecTypes::AluSrc2Type_Reg;
            o.pc = randomBits(12) << 2;
            o.imm = randomBits(32);
            o.src1Value = randomBits(32);
            o.src2Value = randomBits(32);
            o.dstReg = 5'(i);
            operand2 = o.aluSrc2 == ExecTypes::AluSrc2Type_Imm ? o.imm : o.src2Value;
            e = '0;
            e.valid = 1'b1;
            e.pc = o.pc;
            e.dstReg = o.dstReg;
            e.result = aluModel(o.opcode, o.src1Value, operand2);
            e.nextPc = o.pc + 32'd4;
            issueOp(o, e, $sformatf("random %0d", i));
        end
    endtask

    task automatic checkNextResult();
        ExecTypes::ExecResult e;
        string                testName;
        if (expectQueue.size() == 0) begin
            $display("result with pc %h arrived with no operation pending", result.pc);
            $display("tests failed");
            $fatal(1, "extra result");
        end else begin
            e = expectQueue.pop_front();
            testName = nameQueue.pop_front();
            checkValue(testName, "pc", e.pc, result.pc);
            checkValue(testName, "dstReg", 32'(e.dstReg), 32'(result.dstReg));
            checkValue(testName, "result", e.result, result.result);
            checkValue(testName, "branchTaken", 32'(e.branchTaken), 32'(result.branchTaken));
            checkValue(testName, "nextPc", e.nextPc, result.nextPc);
            resultCount++;
        end
    endtask

    // result register is stable at the falling edge
    always @(negedge clk) begin
        if (!reset && result.valid === 1'b1) begin
            checkNextResult();
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        op = '0;
        loadVectors();
        cycleLimit = (fileOps.size() + RandomOps) * 40 + 200;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #(HalfPeriod / 2);
        checkValue("reset", "stall", 32'd0, 32'(stall));
        checkValue("reset", "result valid", 32'd0, 32'(result.valid));
        checkValue("reset", "cyc", 32'd0, 32'(ExecuteSubsystem_i.cyc));
        checkValue("reset", "stb", 32'd0, 32'(ExecuteSubsystem_i.stb));
        @(negedge clk);
        for (int i = 0; i < fileOps.size(); i++) begin
            issueOp(fileOps[i], fileExp[i], $sformatf("vector %0d", i));
        end
        runRandomOps();
        op = '0;
        while (expectQueue.size() != 0) begin
            @(posedge clk);
        end
        // a few idle cycles to catch stray results
        repeat (3) @(negedge clk);
        if (resultCount != acceptedCount) begin
            $display("%0d results for %0d accepted operations", resultCount, acceptedCount);
            $display("tests failed");
            $fatal(1, "result count mismatch");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog/ExecuteSubsystem.sv */
// Execute subsystem
// Execute stage with its load/store unit on a Wishbone classic bus to
// the data RAM.

`timescale 1ns/1ns
`default_nettype none

module ExecuteSubsystem #(
    parameter int DivCycles = 32,
    parameter int RamWords = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  ExecTypes::ExecOp     op,
    output logic                 stall,
    output ExecTypes::ExecResult result
);
    ExecTypes::MemRequest memRequest;
    logic                 memDone;
    ExecTypes::word_t     memLoadValue;

    // wishbone
    logic             cyc;
    logic             stb;
    logic             we;
    logic             ack;
    ExecTypes::word_t adr;
    ExecTypes::word_t datW;
    ExecTypes::word_t datR;

    ExecuteStage #(
        .DivCycles(DivCycles)
    ) executeStage_i (
        .clk(clk),
        .reset(reset),
        .op(op),
        .stall(stall),
        .result(result),
        .memRequest(memRequest),
        .memDone(memDone),
        .memLoadValue(memLoadValue)
    );

    LoadStoreUnit loadStoreUnit_i (
        .clk(clk),
        .reset(reset),
        .request(memRequest),
        .done(memDone),
        .loadValue(memLoadValue),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .datW(datW),
        .datR(datR),
        .ack(ack)
    );

    DataRam #(
        .RamWords(RamWords)
    ) dataRam_i (
        .clk(clk),
        .reset(reset),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .datW(datW),
        .datR(datR),
        .ack(ack)
    );

endmodule

`default_nettype wire

/* verilog/ExecuteStage.sv */
// Integer execute stage
// Picks ALU operands, dispatches to the ALU, the multiply/divide unit or
// the load/store unit, stalls the source until a multi-cycle unit is done
// and registers one result record per completed operation.

`timescale 1ns/1ns
`default_nettype none

module ExecuteStage #(
    parameter int DivCycles = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  ExecTypes::ExecOp     op,
    output logic                 stall,
    output ExecTypes::ExecResult result,
    output ExecTypes::MemRequest memRequest,
    input  logic                 memDone,
    input  ExecTypes::word_t     memLoadValue
);
    ExecTypes::word_t aluSrc1;
    ExecTypes::word_t aluSrc2;
    ExecTypes::word_t aluResult;
    logic             branchTaken;
    logic             isMulDiv;
    logic             isMem;
    logic             mulDivEnable;
    logic             mulDivDone;
    ExecTypes::word_t mulDivResult;
    logic             done;
    ExecTypes::word_t seqPc;
    ExecTypes::word_t finalValue;
    ExecTypes::word_t nextPc;

    always_comb begin
        case (op.aluSrc1)
            ExecTypes::AluSrc1Type_Pc:  aluSrc1 = op.pc;
            ExecTypes::AluSrc1Type_Reg: aluSrc1 = op.src1Value;
            default:                    aluSrc1 = '0;
        endcase
        case (op.aluSrc2)
            ExecTypes::AluSrc2Type_Imm: aluSrc2 = op.imm;
            ExecTypes::AluSrc2Type_Reg: aluSrc2 = op.src2Value;
            default:                    aluSrc2 = '0;
        endcase
    end

    IntAlu intAlu_i (
        .opcode(op.opcode),
        .branchType(op.branchType),
        .src1(aluSrc1),
        .src2(aluSrc2),
        .cmp1(op.src1Value),
        .cmp2(op.src2Value),
        .result(aluResult),
        .branchTaken(branchTaken)
    );

    MulDivUnit #(
        .DivCycles(DivCycles)
    ) mulDivUnit_i (
        .clk(clk),
        .reset(reset),
        .enable(mulDivEnable),
        .opcode(op.opcode),
        .src1(op.src1Value),
        .src2(op.src2Value),
        .done(mulDivDone),
        .result(mulDivResult)
    );

    // unit dispatch and stall
    always_comb begin
        isMulDiv = op.opcode inside {ExecTypes::ExecOpcode_Mul, ExecTypes::ExecOpcode_Mulhu,
                                     ExecTypes::ExecOpcode_Divu, ExecTypes::ExecOpcode_Remu};
        isMem = op.opcode inside {ExecTypes::ExecOpcode_Load, ExecTypes::ExecOpcode_Store};
        mulDivEnable = op.valid && isMulDiv;

        memRequest.enable = op.valid && isMem;
        memRequest.isStore = (op.opcode == ExecTypes::ExecOpcode_Store);
        memRequest.addr = aluResult;
        memRequest.storeValue = op.src2Value;

        if (isMulDiv) begin
            done = mulDivDone;
        end else if (isMem) begin
            done = memDone;
        end else begin
            done = 1'b1;
        end
        stall = op.valid && !done;
    end

    always_comb begin
        seqPc = op.pc + ExecTypes::word_t'(4);
        finalValue = aluResult;
        nextPc = seqPc;
        case (op.opcode)
            ExecTypes::ExecOpcode_Mul,
            ExecTypes::ExecOpcode_Mulhu,
            ExecTypes::ExecOpcode_Divu,
            ExecTypes::ExecOpcode_Remu:  finalValue = mulDivResult;
            ExecTypes::ExecOpcode_Load:  finalValue = memLoadValue;
            ExecTypes::ExecOpcode_Jal: begin
                finalValue = seqPc;
                nextPc = aluResult;
            end
            ExecTypes::ExecOpcode_Branch: begin
                if (branchTaken) begin
                    nextPc = aluResult;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= op.valid && !stall;
            if (op.valid && !stall) begin
                result.pc <= op.pc;
                result.dstReg <= op.dstReg;
                result.result <= finalValue;
                result.branchTaken <= branchTaken;
                result.nextPc <= nextPc;
            end
        end
    end

    // source holds its op while stalled
    opHeldUnderStall: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(op));

endmodule

`default_nettype wire

/* verilog/DataRam.sv */
// Data RAM
// Word-addressed Wishbone classic slave, cleared at reset. Answers each
// strobe with a single registered ack one cycle later.

`timescale 1ns/1ns
`default_nettype none

module DataRam #(
    parameter int RamWords = 256
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  ExecTypes::word_t adr,
    input  ExecTypes::word_t datW,
    output ExecTypes::word_t datR,
    output logic             ack
);
    localparam int IndexBits = $clog2(RamWords);

    ExecTypes::word_t     mem [RamWords];
    logic [IndexBits-1:0] index;
    logic                 request;

    // byte offset dropped
    assign index = adr[IndexBits+1:2];
    assign request = cyc && stb && !ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RamWords; i++) begin
                mem[i] <= '0;
            end
            ack <= 1'b0;
        end else begin
            ack <= request;
            if (request) begin
                if (we) begin
                    mem[index] <= datW;
                end
                datR <= mem[index];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/LoadStoreUnit.sv */
// Load/store unit
// Wishbone classic master doing one word read or write per request.
// done pulses in the cycle after ack, with the read data registered.

`timescale 1ns/1ns
`default_nettype none

module LoadStoreUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  ExecTypes::MemRequest request,
    output logic                 done,
    output ExecTypes::word_t     loadValue,
    output logic                 cyc,
    output logic                 stb,
    output logic                 we,
    output ExecTypes::word_t     adr,
    output ExecTypes::word_t     datW,
    input  ExecTypes::word_t     datR,
    input  logic                 ack
);
    typedef enum logic [1:0] {Idle, Access, Finish} LsuState;

    LsuState state;

    always_comb begin
        cyc = (state == Access);
        stb = (state == Access);
        done = (state == Finish);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: begin
                    if (request.enable) begin
                        state <= Access;
                    end
                end
                Access: begin
                    if (ack) begin
                        state <= Finish;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // bus payload latched at start, read data at ack
    always_ff @(posedge clk) begin
        if (state == Idle && request.enable) begin
            we <= request.isStore;
            adr <= request.addr;
            datW <= request.storeValue;
        end
        if (state == Access && ack) begin
            loadValue <= datR;
        end
    end

    // slave acks only inside a bus cycle
    ackInsideCycle: assert property (@(posedge clk) disable iff (reset)
        ack |-> (cyc && stb));

endmodule

`default_nettype wire

/* verilog/MulDivUnit.sv */
// Multiply / divide unit
// Unsigned multiply through a two-stage registered product, and unsigned
// divide/remainder by a restoring shift-subtract loop. done pulses for one
// cycle when the result is ready.

`timescale 1ns/1ns
`default_nettype none

module MulDivUnit #(
    parameter int DivCycles = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  ExecTypes::ExecOpcode opcode,
    input  ExecTypes::word_t     src1,
    input  ExecTypes::word_t     src2,
    output logic                 done,
    output ExecTypes::word_t     result
);
    localparam int Xlen = ExecTypes::Xlen;
    localparam int CountBits = $clog2(DivCycles + 1);

    typedef enum logic [1:0] {Idle, Multiply, Divide} MulDivState;
    typedef logic [2*Xlen-1:0] product_t;

    MulDivState           state;
    logic [CountBits-1:0] count;
    ExecTypes::ExecOpcode busyOpcode;
    ExecTypes::word_t     opA;
    ExecTypes::word_t     opB;
    product_t             product;
    ExecTypes::word_t     quotient;
    ExecTypes::word_t     remainder;
    logic [Xlen:0]        shifted;
    logic [Xlen:0]        trial;
    logic                 isMultiply;

    assign isMultiply = opcode inside {ExecTypes::ExecOpcode_Mul, ExecTypes::ExecOpcode_Mulhu};

    // trial subtract, borrow in the top bit means keep the shifted remainder
    always_comb begin
        shifted = {remainder, quotient[Xlen-1]};
        trial = shifted - {1'b0, opB};
    end

    always_comb begin
        done = ((state == Multiply) && (count == CountBits'(1))) ||
               ((state == Divide) && (count == CountBits'(DivCycles)));
        case (busyOpcode)
            ExecTypes::ExecOpcode_Mul:   result = product[Xlen-1:0];
            ExecTypes::ExecOpcode_Mulhu: result = product[2*Xlen-1:Xlen];
            ExecTypes::ExecOpcode_Divu:  result = quotient;
            ExecTypes::ExecOpcode_Remu:  result = remainder;
            default:                     result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Idle;
            count <= '0;
        end else begin
            case (state)
                Idle: begin
                    count <= '0;
                    if (enable) begin
                        state <= isMultiply ? Multiply : Divide;
                    end
                end
                default: begin
                    if (done) begin
                        state <= Idle;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle && enable) begin
            busyOpcode <= opcode;
            opA <= src1;
            opB <= src2;
            quotient <= src1;
            remainder <= '0;
        end else if (state == Multiply && count == '0) begin
            product <= product_t'(opA) * product_t'(opB);
        end else if (state == Divide && count < CountBits'(Xlen)) begin
            quotient <= {quotient[Xlen-2:0], ~trial[Xlen]};
            remainder <= trial[Xlen] ? shifted[Xlen-1:0] : trial[Xlen-1:0];
        end
    end

    // the stage holds its op while busy
    busyHoldsOpcode: assert property (@(posedge clk) disable iff (reset)
        (state != Idle && enable) |-> (opcode == busyOpcode));

endmodule

`default_nettype wire

/* verilog/IntAlu.sv */
// Integer ALU
// Single-cycle arithmetic, logic, shift and compare operations, plus the
// address/target add for memory and control ops. The branch comparator
// works on the raw register values, independent of the ALU operands.

`timescale 1ns/1ns
`default_nettype none

module IntAlu (
    input  ExecTypes::ExecOpcode opcode,
    input  ExecTypes::BranchType branchType,
    input  ExecTypes::word_t     src1,
    input  ExecTypes::word_t     src2,
    input  ExecTypes::word_t     cmp1,
    input  ExecTypes::word_t     cmp2,
    output ExecTypes::word_t     result,
    output logic                 branchTaken
);
    localparam int ShiftBits = $clog2(ExecTypes::Xlen);

    logic [ShiftBits-1:0] shamt;
    logic                 compare;

    assign shamt = src2[ShiftBits-1:0];

    always_comb begin
        case (opcode)
            ExecTypes::ExecOpcode_Sub:  result = src1 - src2;
            ExecTypes::ExecOpcode_Sll:  result = src1 << shamt;
            ExecTypes::ExecOpcode_Slt:  result = ExecTypes::word_t'($signed(src1) < $signed(src2));
            ExecTypes::ExecOpcode_Sltu: result = ExecTypes::word_t'(src1 < src2);
            ExecTypes::ExecOpcode_Xor:  result = src1 ^ src2;
            ExecTypes::ExecOpcode_Srl:  result = src1 >> shamt;
            ExecTypes::ExecOpcode_Sra:  result = $unsigned($signed(src1) >>> shamt);
            ExecTypes::ExecOpcode_Or:   result = src1 | src2;
            ExecTypes::ExecOpcode_And:  result = src1 & src2;
            // add, plus load/store address and branch/jump target
            default:                    result = src1 + src2;
        endcase
    end

    always_comb begin
        case (branchType)
            ExecTypes::BranchType_Equal:                compare = cmp1 == cmp2;
            ExecTypes::BranchType_NotEqual:             compare = cmp1 != cmp2;
            ExecTypes::BranchType_LessThan:             compare = $signed(cmp1) < $signed(cmp2);
            ExecTypes::BranchType_GreaterEqual:         compare = $signed(cmp1) >= $signed(cmp2);
            ExecTypes::BranchType_UnsignedLessThan:     compare = cmp1 < cmp2;
            ExecTypes::BranchType_UnsignedGreaterEqual: compare = cmp1 >= cmp2;
            default:                                    compare = 1'b0;
        endcase
        branchTaken = (opcode == ExecTypes::ExecOpcode_Branch) && compare;
    end

endmodule

`default_nettype wire

/* verilog/ExecTypes.sv */
// Execute stage types
// Word width, opcodes, operand source and branch encodings, and the
// operation, result and memory request records shared by the stage.

`default_nettype none

package ExecTypes;

    localparam int Xlen = 32;

    typedef logic [Xlen-1:0] word_t;

    typedef enum logic [4:0] {
        ExecOpcode_Add,
        ExecOpcode_Sub,
        ExecOpcode_Sll,
        ExecOpcode_Slt,
        ExecOpcode_Sltu,
        ExecOpcode_Xor,
        ExecOpcode_Srl,
        ExecOpcode_Sra,
        ExecOpcode_Or,
        ExecOpcode_And,
        ExecOpcode_Mul,
        ExecOpcode_Mulhu,
        ExecOpcode_Divu,
        ExecOpcode_Remu,
        ExecOpcode_Load,
        ExecOpcode_Store,
        ExecOpcode_Branch,
        ExecOpcode_Jal
    } ExecOpcode;

    typedef enum logic [1:0] {
        AluSrc1Type_Zero,
        AluSrc1Type_Pc,
        AluSrc1Type_Reg
    } AluSrc1Type;

    typedef enum logic [1:0] {
        AluSrc2Type_Zero,
        AluSrc2Type_Imm,
        AluSrc2Type_Reg
    } AluSrc2Type;

    typedef enum logic [2:0] {
        BranchType_Equal,
        BranchType_NotEqual,
        BranchType_LessThan,
        BranchType_GreaterEqual,
        BranchType_UnsignedLessThan,
        BranchType_UnsignedGreaterEqual
    } BranchType;

    typedef struct packed {
        logic       valid;
        ExecOpcode  opcode;
        AluSrc1Type aluSrc1;
        AluSrc2Type aluSrc2;
        BranchType  branchType;
        word_t      pc;
        word_t      imm;
        word_t      src1Value;
        word_t      src2Value;
        logic [4:0] dstReg;
    } ExecOp;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        logic [4:0] dstReg;
        word_t      result;
        logic       branchTaken;
        word_t      nextPc;
    } ExecResult;

    typedef struct packed {
        logic  enable;
        logic  isStore;
        word_t addr;
        word_t storeValue;
    } MemRequest;

endpackage

`default_nettype wire
